//--- rtl/cnn_pkg.sv
package cnn_pkg;

	// ----------------------------------------------------------
	// Fixed sizes and bus constants
	// ----------------------------------------------------------
	localparam int N_TAPS  = 9;
	localparam int REG_LSB = 2;
	localparam int PIX_LSB = 6;

	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ    = 2'b11;
	localparam logic       HRESP_OKAY    = 1'b0;

	// Slave register map, word index in haddr[5:2]
	typedef enum logic [3:0] {
		REG_WIDTH_HEIGHT = 4'd0,
		REG_DELAY        = 4'd1,
		REG_LAYER_CFG    = 4'd2,
		REG_WEIGHT       = 4'd3,
		REG_PARAM        = 4'd4,
		REG_IMAGE        = 4'd5,
		REG_START        = 4'd6,
		REG_DONE         = 4'd7
	} reg_idx_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_STARTUP,
		ST_HSYNC,
		ST_DATA
	} ctrl_state_e;

	// ----------------------------------------------------------
	// Data types
	// ----------------------------------------------------------
	typedef logic        [11:0] dim_t;
	typedef logic        [11:0] delay_t;
	typedef logic        [7:0]  pix_t;
	typedef logic signed [7:0]  weight_t;
	// Window position 0..8 in raster order
	typedef logic        [3:0]  tap_t;
	typedef logic signed [19:0] acc_t;
	typedef logic signed [15:0] param_t;
	typedef logic        [4:0]  shift_t;
	typedef logic signed [47:0] prod_t;

	localparam tap_t TAP_CENTRE = 4'd4;

endpackage

//--- rtl/ahb_cfg_slave.sv
`timescale 1ns/100ps

module ahb_cfg_slave #(
	parameter int MAX_W          = 16,
	parameter int MAX_H          = 16,
	parameter int START_UP_DELAY = 4,
	parameter int HSYNC_DELAY    = 2,
	localparam int ADDR_W        = $clog2(MAX_W * MAX_H)
) (
	input  logic                                     clk,
	input  logic                                     rstn,
	input  logic                                     hsel_i,
	input  logic                                     hready_i,
	input  logic [1:0]                               htrans_i,
	input  logic                                     hwrite_i,
	input  logic [31:0]                              haddr_i,
	input  logic [31:0]                              hwdata_i,
	input  logic                                     busy_i,
	input  logic                                     frame_last_i,
	output logic                                     hreadyout_o,
	output logic                                     hresp_o,
	output logic [31:0]                              hrdata_o,
	output cnn_pkg::dim_t                            width_o,
	output cnn_pkg::dim_t                            height_o,
	output cnn_pkg::delay_t                          startup_dly_o,
	output cnn_pkg::delay_t                          hsync_dly_o,
	output logic                                     is_conv3x3_o,
	output logic                                     act_linear_o,
	output cnn_pkg::shift_t                          bias_shift_o,
	output cnn_pkg::shift_t                          out_shift_o,
	output cnn_pkg::param_t                          scale_o,
	output cnn_pkg::param_t                          bias_o,
	output cnn_pkg::weight_t [cnn_pkg::N_TAPS-1:0]   weights_o,
	output logic                                     img_we_o,
	output logic [ADDR_W-1:0]                        img_addr_o,
	output cnn_pkg::pix_t                            img_data_o,
	output logic                                     start_o
);
	import cnn_pkg::*;

	reg_idx_e          sel_q;
	logic              wr_q;
	logic [ADDR_W-1:0] pix_idx_q;
	logic              done_q;

	assign hreadyout_o = 1'b1;
	assign hresp_o     = HRESP_OKAY;

	// ----------------------------------------------------------
	// Address phase
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			sel_q     <= REG_WIDTH_HEIGHT;
			wr_q      <= 1'b0;
			pix_idx_q <= '0;
		end else if (hsel_i && hready_i &&
				(htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ)) begin
			sel_q     <= reg_idx_e'(haddr_i[REG_LSB +: 4]);
			wr_q      <= hwrite_i;
			pix_idx_q <= haddr_i[PIX_LSB +: ADDR_W];
		end else begin
			wr_q <= 1'b0;
		end
	end

	// ----------------------------------------------------------
	// Data phase writes
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			width_o       <= dim_t'(MAX_W);
			height_o      <= dim_t'(MAX_H);
			startup_dly_o <= delay_t'(START_UP_DELAY);
			hsync_dly_o   <= delay_t'(HSYNC_DELAY);
			is_conv3x3_o  <= 1'b1;
			act_linear_o  <= 1'b0;
			bias_shift_o  <= '0;
			out_shift_o   <= '0;
			scale_o       <= param_t'(1);
			bias_o        <= '0;
			weights_o     <= '0;
		end else if (wr_q) begin
			case (sel_q)
				REG_WIDTH_HEIGHT: begin
					width_o  <= hwdata_i[11:0];
					height_o <= hwdata_i[27:16];
				end
				REG_DELAY: begin
					startup_dly_o <= hwdata_i[11:0];
					hsync_dly_o   <= hwdata_i[23:12];
				end
				REG_LAYER_CFG: begin
					is_conv3x3_o <= hwdata_i[0];
					act_linear_o <= hwdata_i[1];
					bias_shift_o <= hwdata_i[12:8];
					out_shift_o  <= hwdata_i[20:16];
				end
				REG_WEIGHT: begin
					// Tap index beyond the window is dropped
					if (hwdata_i[3:0] < N_TAPS)
						weights_o[hwdata_i[3:0]] <= weight_t'(hwdata_i[15:8]);
				end
				REG_PARAM: begin
					scale_o <= hwdata_i[15:0];
					bias_o  <= hwdata_i[31:16];
				end
				default: begin
				end
			endcase
		end
	end

	// Pixel write goes straight to the image buffer
	assign img_we_o   = wr_q && (sel_q == REG_IMAGE);
	assign img_addr_o = pix_idx_q;
	assign img_data_o = hwdata_i[7:0];

	// Start pulse and done flag
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			start_o <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			start_o <= wr_q && (sel_q == REG_START) && hwdata_i[0] && !busy_i;
			if (start_o)
				done_q <= 1'b0;
			else if (frame_last_i)
				done_q <= 1'b1;
		end
	end

	// ----------------------------------------------------------
	// Read data
	// ----------------------------------------------------------
	always_comb begin
		case (sel_q)
			REG_WIDTH_HEIGHT: hrdata_o = {4'b0, height_o, 4'b0, width_o};
			REG_DELAY:        hrdata_o = {8'b0, hsync_dly_o, startup_dly_o};
			REG_LAYER_CFG:    hrdata_o = {11'b0, out_shift_o, 3'b0, bias_shift_o,
						6'b0, act_linear_o, is_conv3x3_o};
			REG_PARAM:        hrdata_o = {bias_o, scale_o};
			REG_START:        hrdata_o = {31'b0, busy_i};
			REG_DONE:         hrdata_o = {31'b0, done_q};
			default:          hrdata_o = 32'h0;
		endcase
	end

endmodule

//--- rtl/conv_frame_ctrl.sv
`timescale 1ns/100ps

module conv_frame_ctrl (
	input  logic            clk,
	input  logic            rstn,
	input  logic            start_i,
	input  cnn_pkg::dim_t   width_i,
	input  cnn_pkg::dim_t   height_i,
	input  cnn_pkg::delay_t startup_dly_i,
	input  cnn_pkg::delay_t hsync_dly_i,
	input  logic            is_conv3x3_i,
	output logic            tap_vld_o,
	output cnn_pkg::tap_t   tap_o,
	output cnn_pkg::dim_t   row_o,
	output cnn_pkg::dim_t   col_o,
	output logic            first_tap_o,
	output logic            last_tap_o,
	output logic            frame_end_o,
	output logic            busy_o
);
	import cnn_pkg::*;

	ctrl_state_e state;
	delay_t      dly_cnt;
	dim_t        row;
	dim_t        col;
	tap_t        tap;
	tap_t        tap_start;
	logic        first_tap;
	logic        last_tap;
	logic        last_col;
	logic        last_row;

	// 1x1 mode only visits the centre tap
	assign tap_start = is_conv3x3_i ? tap_t'(0) : TAP_CENTRE;
	assign first_tap = is_conv3x3_i ? (tap == tap_t'(0)) : 1'b1;
	assign last_tap  = is_conv3x3_i ? (tap == tap_t'(N_TAPS - 1)) : 1'b1;
	assign last_col  = (col == width_i - dim_t'(1));
	assign last_row  = (row == height_i - dim_t'(1));

	// ----------------------------------------------------------
	// Frame sequencing
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state   <= ST_IDLE;
			dly_cnt <= '0;
			row     <= '0;
			col     <= '0;
			tap     <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start_i) begin
						state   <= ST_STARTUP;
						dly_cnt <= startup_dly_i;
						row     <= '0;
						col     <= '0;
					end
				end
				ST_STARTUP: begin
					if (dly_cnt == '0) begin
						state   <= ST_HSYNC;
						dly_cnt <= hsync_dly_i;
					end else begin
						dly_cnt <= dly_cnt - 1'b1;
					end
				end
				ST_HSYNC: begin
					if (dly_cnt == '0) begin
						state <= ST_DATA;
						tap   <= tap_start;
					end else begin
						dly_cnt <= dly_cnt - 1'b1;
					end
				end
				ST_DATA: begin
					if (!last_tap) begin
						tap <= tap + 1'b1;
					end else begin
						tap <= tap_start;
						if (!last_col) begin
							col <= col + 1'b1;
						end else begin
							col <= '0;
							if (last_row) begin
								state <= ST_IDLE;
							end else begin
								// Next row waits the row delay again
								row     <= row + 1'b1;
								dly_cnt <= hsync_dly_i;
								state   <= ST_HSYNC;
							end
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// One tap per cycle while in ST_DATA
	assign tap_vld_o   = (state == ST_DATA);
	assign tap_o       = tap;
	assign row_o       = row;
	assign col_o       = col;
	assign first_tap_o = tap_vld_o & first_tap;
	assign last_tap_o  = tap_vld_o & last_tap;
	assign frame_end_o = last_tap_o & last_col & last_row;
	assign busy_o      = (state != ST_IDLE);

endmodule

//--- rtl/window_fetch.sv
`timescale 1ns/100ps

module window_fetch #(
	parameter int MAX_W  = 16,
	parameter int MAX_H  = 16,
	localparam int ADDR_W = $clog2(MAX_W * MAX_H)
) (
	input  logic              clk,
	input  logic              rstn,
	input  logic              img_we_i,
	input  logic [ADDR_W-1:0] img_addr_i,
	input  cnn_pkg::pix_t     img_data_i,
	input  logic              tap_vld_i,
	input  cnn_pkg::tap_t     tap_i,
	input  cnn_pkg::dim_t     row_i,
	input  cnn_pkg::dim_t     col_i,
	input  logic              first_tap_i,
	input  logic              last_tap_i,
	input  logic              frame_end_i,
	input  cnn_pkg::dim_t     width_i,
	input  cnn_pkg::dim_t     height_i,
	output logic              px_vld_o,
	output cnn_pkg::pix_t     px_o,
	output cnn_pkg::tap_t     px_tap_o,
	output logic              px_first_o,
	output logic              px_last_o,
	output logic              px_frame_end_o
);
	import cnn_pkg::*;

	pix_t              mem [MAX_W * MAX_H];
	logic              up;
	logic              down;
	logic              left;
	logic              right;
	logic              pad;
	dim_t              nb_row;
	dim_t              nb_col;
	logic [23:0]       nb_lin;
	logic [ADDR_W-1:0] rd_addr;

	// ----------------------------------------------------------
	// Neighbour address from the tap offset
	// ----------------------------------------------------------
	assign up    = (tap_i <= 4'd2);
	assign down  = (tap_i >= 4'd6);
	assign left  = (tap_i == 4'd0) || (tap_i == 4'd3) || (tap_i == 4'd6);
	assign right = (tap_i == 4'd2) || (tap_i == 4'd5) || (tap_i == 4'd8);

	// Taps that fall off the frame edge read as zero
	assign pad = (up    && row_i == '0) ||
		     (down  && row_i == height_i - dim_t'(1)) ||
		     (left  && col_i == '0) ||
		     (right && col_i == width_i - dim_t'(1));

	assign nb_row  = row_i - dim_t'(up) + dim_t'(down);
	assign nb_col  = col_i - dim_t'(left) + dim_t'(right);
	// Image stored in raster order at the current frame width
	assign nb_lin  = nb_row * width_i + nb_col;
	assign rd_addr = nb_lin[ADDR_W-1:0];

	always_ff @(posedge clk) begin
		if (img_we_i)
			mem[img_addr_i] <= img_data_i;
	end

	always_ff @(posedge clk) begin
		px_o     <= pad ? '0 : mem[rd_addr];
		px_tap_o <= tap_i;
	end

	// Flags follow the read by one cycle
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			px_vld_o       <= 1'b0;
			px_first_o     <= 1'b0;
			px_last_o      <= 1'b0;
			px_frame_end_o <= 1'b0;
		end else begin
			px_vld_o       <= tap_vld_i;
			px_first_o     <= first_tap_i;
			px_last_o      <= last_tap_i;
			px_frame_end_o <= frame_end_i;
		end
	end

endmodule

//--- rtl/conv_mac.sv
`timescale 1ns/100ps

module conv_mac (
	input  logic                                   clk,
	input  logic                                   rstn,
	input  logic                                   px_vld_i,
	input  cnn_pkg::pix_t                          px_i,
	input  cnn_pkg::tap_t                          px_tap_i,
	input  logic                                   px_first_i,
	input  logic                                   px_last_i,
	input  logic                                   px_frame_end_i,
	input  cnn_pkg::weight_t [cnn_pkg::N_TAPS-1:0] weights_i,
	output logic                                   acc_vld_o,
	output cnn_pkg::acc_t                          acc_o,
	output logic                                   acc_frame_end_o
);
	import cnn_pkg::*;

	logic signed [16:0] prod;
	acc_t               acc_base;

	// Unsigned pixel times signed weight
	assign prod     = $signed({1'b0, px_i}) * weights_i[px_tap_i];
	assign acc_base = px_first_i ? acc_t'(0) : acc_o;

	always_ff @(posedge clk) begin
		if (px_vld_i)
			acc_o <= acc_base + acc_t'(prod);
	end

	// Sum is complete the cycle after the last tap
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			acc_vld_o       <= 1'b0;
			acc_frame_end_o <= 1'b0;
		end else begin
			acc_vld_o       <= px_vld_i & px_last_i;
			acc_frame_end_o <= px_vld_i & px_last_i & px_frame_end_i;
		end
	end

endmodule

//--- rtl/requant_act.sv
`timescale 1ns/100ps

module requant_act (
	input  logic            clk,
	input  logic            rstn,
	input  logic            acc_vld_i,
	input  cnn_pkg::acc_t   acc_i,
	input  logic            acc_frame_end_i,
	input  cnn_pkg::param_t scale_i,
	input  cnn_pkg::param_t bias_i,
	input  cnn_pkg::shift_t bias_shift_i,
	input  cnn_pkg::shift_t out_shift_i,
	input  logic            act_linear_i,
	output logic            pix_vld_o,
	output cnn_pkg::pix_t   pix_o,
	output logic            frame_last_o
);
	import cnn_pkg::*;

	prod_t scaled;
	prod_t bias_ext;
	prod_t shifted;
	pix_t  act;

	// ----------------------------------------------------------
	// Scale, bias and output shift
	// ----------------------------------------------------------
	assign scaled   = prod_t'(acc_i) * prod_t'(scale_i);
	assign bias_ext = prod_t'(bias_i) <<< bias_shift_i;
	assign shifted  = (scaled + bias_ext) >>> out_shift_i;

	always_comb begin
		if (act_linear_i) begin
			// Signed byte range
			if (shifted < -128)
				act = 8'h80;
			else if (shifted > 127)
				act = 8'h7f;
			else
				act = shifted[7:0];
		end else begin
			if (shifted < 0)
				act = 8'h00;
			else if (shifted > 255)
				act = 8'hff;
			else
				act = shifted[7:0];
		end
	end

	always_ff @(posedge clk) begin
		if (acc_vld_i)
			pix_o <= act;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			pix_vld_o    <= 1'b0;
			frame_last_o <= 1'b0;
		end else begin
			pix_vld_o    <= acc_vld_i;
			frame_last_o <= acc_vld_i & acc_frame_end_i;
		end
	end

endmodule

//--- rtl/cnn_conv_top.sv
`timescale 1ns/100ps

module cnn_conv_top #(
	parameter int MAX_W          = 16,
	parameter int MAX_H          = 16,
	parameter int START_UP_DELAY = 4,
	parameter int HSYNC_DELAY    = 2
) (
	input  logic          clk,
	input  logic          rstn,
	input  logic          hsel_i,
	input  logic          hready_i,
	input  logic [1:0]    htrans_i,
	input  logic          hwrite_i,
	input  logic [31:0]   haddr_i,
	input  logic [31:0]   hwdata_i,
	output logic          hreadyout_o,
	output logic          hresp_o,
	output logic [31:0]   hrdata_o,
	output cnn_pkg::pix_t pix_o,
	output logic          pix_vld_o,
	output logic          frame_last_o
);
	import cnn_pkg::*;

	localparam int ADDR_W = $clog2(MAX_W * MAX_H);

	// Configuration
	dim_t                     width;
	dim_t                     height;
	delay_t                   startup_dly;
	delay_t                   hsync_dly;
	logic                     is_conv3x3;
	logic                     act_linear;
	shift_t                   bias_shift;
	shift_t                   out_shift;
	param_t                   scale;
	param_t                   bias;
	weight_t [N_TAPS-1:0]     weights;
	logic                     img_we;
	logic [ADDR_W-1:0]        img_addr;
	pix_t                     img_data;
	logic                     start;
	logic                     busy;

	// Tap stream
	logic                     tap_vld;
	tap_t                     tap;
	dim_t                     row;
	dim_t                     col;
	logic                     first_tap;
	logic                     last_tap;
	logic                     frame_end;

	// Datapath
	logic                     px_vld;
	pix_t                     px;
	tap_t                     px_tap;
	logic                     px_first;
	logic                     px_last;
	logic                     px_frame_end;
	logic                     acc_vld;
	acc_t                     acc;
	logic                     acc_frame_end;

	// ----------------------------------------------------------
	// Slave and controller
	// ----------------------------------------------------------
	ahb_cfg_slave #(
		.MAX_W(MAX_W), .MAX_H(MAX_H),
		.START_UP_DELAY(START_UP_DELAY), .HSYNC_DELAY(HSYNC_DELAY)
	) u_slave (
		.clk(clk), .rstn(rstn),
		.hsel_i(hsel_i), .hready_i(hready_i), .htrans_i(htrans_i),
		.hwrite_i(hwrite_i), .haddr_i(haddr_i), .hwdata_i(hwdata_i),
		.busy_i(busy), .frame_last_i(frame_last_o),
		.hreadyout_o(hreadyout_o), .hresp_o(hresp_o), .hrdata_o(hrdata_o),
		.width_o(width), .height_o(height),
		.startup_dly_o(startup_dly), .hsync_dly_o(hsync_dly),
		.is_conv3x3_o(is_conv3x3), .act_linear_o(act_linear),
		.bias_shift_o(bias_shift), .out_shift_o(out_shift),
		.scale_o(scale), .bias_o(bias), .weights_o(weights),
		.img_we_o(img_we), .img_addr_o(img_addr), .img_data_o(img_data),
		.start_o(start)
	);

	conv_frame_ctrl u_ctrl (
		.clk(clk), .rstn(rstn), .start_i(start),
		.width_i(width), .height_i(height),
		.startup_dly_i(startup_dly), .hsync_dly_i(hsync_dly),
		.is_conv3x3_i(is_conv3x3),
		.tap_vld_o(tap_vld), .tap_o(tap), .row_o(row), .col_o(col),
		.first_tap_o(first_tap), .last_tap_o(last_tap),
		.frame_end_o(frame_end), .busy_o(busy)
	);

	// ----------------------------------------------------------
	// Fetch, MAC and requantisation
	// ----------------------------------------------------------
	window_fetch #(.MAX_W(MAX_W), .MAX_H(MAX_H)) u_fetch (
		.clk(clk), .rstn(rstn),
		.img_we_i(img_we), .img_addr_i(img_addr), .img_data_i(img_data),
		.tap_vld_i(tap_vld), .tap_i(tap), .row_i(row), .col_i(col),
		.first_tap_i(first_tap), .last_tap_i(last_tap), .frame_end_i(frame_end),
		.width_i(width), .height_i(height),
		.px_vld_o(px_vld), .px_o(px), .px_tap_o(px_tap),
		.px_first_o(px_first), .px_last_o(px_last), .px_frame_end_o(px_frame_end)
	);

	conv_mac u_mac (
		.clk(clk), .rstn(rstn),
		.px_vld_i(px_vld), .px_i(px), .px_tap_i(px_tap),
		.px_first_i(px_first), .px_last_i(px_last), .px_frame_end_i(px_frame_end),
		.weights_i(weights),
		.acc_vld_o(acc_vld), .acc_o(acc), .acc_frame_end_o(acc_frame_end)
	);

	requant_act u_requant (
		.clk(clk), .rstn(rstn),
		.acc_vld_i(acc_vld), .acc_i(acc), .acc_frame_end_i(acc_frame_end),
		.scale_i(scale), .bias_i(bias),
		.bias_shift_i(bias_shift), .out_shift_i(out_shift),
		.act_linear_i(act_linear),
		.pix_vld_o(pix_vld_o), .pix_o(pix_o), .frame_last_o(frame_last_o)
	);

endmodule

//--- sim/tb_ahb_tasks.svh
`ifndef TB_AHB_TASKS_SVH
`define TB_AHB_TASKS_SVH

// ------------------------------------------------------------
// AHB-Lite transfers
// ------------------------------------------------------------
localparam logic [1:0] HTRANS_IDLE = 2'b00;

function automatic logic [31:0] reg_addr(input reg_idx_e idx);
	return 32'(idx) << REG_LSB;
endfunction

// Pixel index sits above the register index
function automatic logic [31:0] pix_addr(input int idx);
	return (32'(idx) << PIX_LSB) | reg_addr(REG_IMAGE);
endfunction

task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
	hsel   = 1'b1;
	htrans = HTRANS_NONSEQ;
	hwrite = 1'b1;
	haddr  = addr;
	@(posedge clk);
	#1;
	// Data phase with the bus idle behind it
	hsel   = 1'b0;
	htrans = HTRANS_IDLE;
	hwrite = 1'b0;
	hwdata = data;
	@(posedge clk);
	#1;
endtask

task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
	hsel   = 1'b1;
	htrans = HTRANS_NONSEQ;
	hwrite = 1'b0;
	haddr  = addr;
	@(posedge clk);
	#1;
	hsel   = 1'b0;
	htrans = HTRANS_IDLE;
	// hrdata follows the index latched in the address phase
	data   = hrdata;
	@(posedge clk);
	#1;
endtask

// ------------------------------------------------------------
// Galois LFSR, one step per bit taken
// ------------------------------------------------------------
logic [31:0] lfsr;

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v    = {v[30:0], lfsr[0]};
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd0000001) : (lfsr >> 1);
	end
	return v;
endfunction

// ------------------------------------------------------------
// Compare tasks
// ------------------------------------------------------------
task automatic check_pix(input string what, input pix_t exp, input pix_t act);
	if (act !== exp)
		abort_run($sformatf("ERROR %s %s: expected %0d, actual %0d",
			test_name, what, exp, act));
endtask

task automatic check_word(input string what, input logic [31:0] exp,
		input logic [31:0] act);
	if (act !== exp)
		abort_run($sformatf("ERROR %s %s: expected 0x%08h, actual 0x%08h",
			test_name, what, exp, act));
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
	if (act !== exp)
		abort_run($sformatf("ERROR %s %s: expected %b, actual %b",
			test_name, what, exp, act));
endtask

`endif

//--- sim/tb_cnn_conv.sv
`timescale 1ns/100ps

module tb_cnn_conv;
	import cnn_pkg::*;

	localparam int MAX_W          = 16;
	localparam int MAX_H          = 16;
	localparam int START_UP_DELAY = 4;
	localparam int HSYNC_DELAY    = 2;
	localparam int DONE_POLLS     = 2000;

	logic        clk;
	logic        rstn;
	logic        hsel;
	logic        hready;
	logic [1:0]  htrans;
	logic        hwrite;
	logic [31:0] haddr;
	logic [31:0] hwdata;
	logic        hreadyout;
	logic        hresp;
	logic [31:0] hrdata;
	pix_t        pix;
	logic        pix_vld;
	logic        frame_last;

	// Copy of everything the host wrote
	pix_t    img_ref [MAX_W * MAX_H];
	weight_t w_ref [N_TAPS];
	int      cfg_w;
	int      cfg_h;
	logic    cfg_conv3x3;
	logic    cfg_linear;
	shift_t  cfg_bshift;
	shift_t  cfg_oshift;
	param_t  cfg_scale;
	param_t  cfg_bias;

	int      out_cnt;
	int      frame_len;
	string   test_name;

	cnn_conv_top #(
		.MAX_W(MAX_W), .MAX_H(MAX_H),
		.START_UP_DELAY(START_UP_DELAY), .HSYNC_DELAY(HSYNC_DELAY)
	) DUT (
		.clk(clk), .rstn(rstn),
		.hsel_i(hsel), .hready_i(hready), .htrans_i(htrans),
		.hwrite_i(hwrite), .haddr_i(haddr), .hwdata_i(hwdata),
		.hreadyout_o(hreadyout), .hresp_o(hresp), .hrdata_o(hrdata),
		.pix_o(pix), .pix_vld_o(pix_vld), .frame_last_o(frame_last)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	`include "tb_ahb_tasks.svh"

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------
	function automatic pix_t ref_pixel(input int row, input int col);
		longint sum;
		longint v;
		int     r;
		int     c;
		sum = 0;
		for (int k = 0; k < N_TAPS; k++) begin
			r = row + k / 3 - 1;
			c = col + k % 3 - 1;
			// Off-frame taps count as zero and 1x1 keeps only the centre
			if ((cfg_conv3x3 || k == 4) && r >= 0 && r < cfg_h && c >= 0 && c < cfg_w)
				sum += longint'(img_ref[r * cfg_w + c]) * longint'(w_ref[k]);
		end
		v = sum * longint'(cfg_scale) + (longint'(cfg_bias) <<< cfg_bshift);
		v = v >>> cfg_oshift;
		if (cfg_linear) begin
			if (v < -128)
				v = -128;
			else if (v > 127)
				v = 127;
		end else begin
			if (v < 0)
				v = 0;
			else if (v > 255)
				v = 255;
		end
		return pix_t'(v);
	endfunction

	// Output stream in raster order
	always @(negedge clk) begin : compare_outputs
		int r;
		int c;
		if (rstn) begin
			check_flag("hreadyout_o", 1'b1, hreadyout);
			check_flag("hresp_o", HRESP_OKAY, hresp);
			if (pix_vld) begin
				if (out_cnt >= frame_len)
					abort_run($sformatf("Extra output pixel beyond the frame in %s",
						test_name));
				r = out_cnt / cfg_w;
				c = out_cnt % cfg_w;
				check_pix($sformatf("pix_o row %0d col %0d", r, c), ref_pixel(r, c), pix);
				check_flag("frame_last_o", out_cnt == frame_len - 1, frame_last);
				out_cnt++;
			end else begin
				check_flag("frame_last_o without pix_vld_o", 1'b0, frame_last);
			end
		end
	end

	// ------------------------------------------------------------
	// Register access
	// ------------------------------------------------------------
	task automatic expect_reg(input reg_idx_e idx, input logic [31:0] exp);
		logic [31:0] rd;
		ahb_read(reg_addr(idx), rd);
		check_word(idx.name(), exp, rd);
	endtask

	task automatic set_dims(input int w, input int h);
		cfg_w = w;
		cfg_h = h;
		ahb_write(reg_addr(REG_WIDTH_HEIGHT), {4'b0, 12'(h), 4'b0, 12'(w)});
	endtask

	task automatic set_delays(input int startup, input int hsync);
		ahb_write(reg_addr(REG_DELAY), {8'b0, 12'(hsync), 12'(startup)});
	endtask

	task automatic set_layer(input logic conv3x3, input logic linear,
			input shift_t bshift, input shift_t oshift);
		cfg_conv3x3 = conv3x3;
		cfg_linear  = linear;
		cfg_bshift  = bshift;
		cfg_oshift  = oshift;
		ahb_write(reg_addr(REG_LAYER_CFG),
			{11'b0, oshift, 3'b0, bshift, 6'b0, linear, conv3x3});
	endtask

	task automatic set_params(input param_t scale, input param_t bias);
		cfg_scale = scale;
		cfg_bias  = bias;
		ahb_write(reg_addr(REG_PARAM), {bias, scale});
	endtask

	task automatic set_weight(input int k, input weight_t w);
		w_ref[k] = w;
		ahb_write(reg_addr(REG_WEIGHT), {16'b0, w, 4'b0, 4'(k)});
	endtask

	task automatic write_pixel(input int i, input pix_t v);
		img_ref[i] = v;
		ahb_write(pix_addr(i), {24'b0, v});
	endtask

	task automatic load_weights();
		for (int k = 0; k < N_TAPS; k++)
			set_weight(k, weight_t'(rand_bits(8)));
	endtask

	task automatic load_image();
		for (int i = 0; i < cfg_w * cfg_h; i++)
			write_pixel(i, pix_t'(rand_bits(8)));
	endtask

	// ------------------------------------------------------------
	// Frame runs
	// ------------------------------------------------------------
	task automatic wait_done();
		logic [31:0] rd;
		int          polls;
		polls = 0;
		rd    = '0;
		while (rd[0] !== 1'b1) begin
			if (polls == DONE_POLLS)
				abort_run($sformatf("Timeout in %s: done flag never set", test_name));
			ahb_read(reg_addr(REG_DONE), rd);
			polls++;
		end
		check_word("pixel count", 32'(frame_len), 32'(out_cnt));
	endtask

	task automatic run_frame(input logic restart_while_busy);
		out_cnt   = 0;
		frame_len = cfg_w * cfg_h;
		ahb_write(reg_addr(REG_START), 32'h1);
		// Start clears a done left from the last frame
		expect_reg(REG_DONE, 32'h0);
		if (restart_while_busy) begin
			expect_reg(REG_START, 32'h1);
			ahb_write(reg_addr(REG_START), 32'h1);
		end
		wait_done();
	endtask

	task automatic reg_access_test();
		logic [31:0] rd;
		test_name = "reset_values";
		expect_reg(REG_WIDTH_HEIGHT, {4'b0, 12'(MAX_H), 4'b0, 12'(MAX_W)});
		expect_reg(REG_DELAY, {8'b0, 12'(HSYNC_DELAY), 12'(START_UP_DELAY)});
		expect_reg(REG_LAYER_CFG, 32'h0000_0001);
		expect_reg(REG_PARAM, 32'h0000_0001);
		expect_reg(REG_WEIGHT, 32'h0);
		expect_reg(REG_START, 32'h0);
		expect_reg(REG_DONE, 32'h0);
		ahb_read(32'd36, rd);
		check_word("undefined index", 32'h0, rd);

		test_name = "readback";
		set_dims(6, 5);
		expect_reg(REG_WIDTH_HEIGHT, 32'h0005_0006);
		set_delays(3, 1);
		expect_reg(REG_DELAY, 32'h0000_1003);
		set_layer(1'b1, 1'b0, 5'd3, 5'd7);
		expect_reg(REG_LAYER_CFG, 32'h0007_0301);
		set_params(param_t'(1), param_t'(40));
		expect_reg(REG_PARAM, 32'h0028_0001);
		set_weight(2, weight_t'(-5));
		expect_reg(REG_WEIGHT, 32'h0);
		expect_reg(REG_DONE, 32'h0);
	endtask

	task automatic conv3x3_relu_test();
		test_name = "conv3x3_relu";
		load_weights();
		load_image();
		run_frame(1'b0);
		expect_reg(REG_DONE, 32'h1);
	endtask

	task automatic conv1x1_linear_test();
		test_name = "conv1x1_linear";
		set_layer(1'b0, 1'b1, 5'd0, 5'd1);
		set_params(param_t'(-2), param_t'(-400));
		set_weight(4, weight_t'(-3));
		load_image();
		// Both ends of the signed range
		write_pixel(0, 8'd0);
		write_pixel(1, 8'd255);
		run_frame(1'b0);
	endtask

	task automatic resize_test();
		test_name = "resize_4x4";
		set_dims(4, 4);
		set_delays(6, 3);
		set_layer(1'b1, 1'b0, 5'd2, 5'd4);
		set_params(param_t'(3), param_t'(25));
		load_weights();
		load_image();
		run_frame(1'b0);
	endtask

	task automatic busy_start_test();
		test_name = "start_while_busy";
		run_frame(1'b1);
		repeat (20) @(posedge clk);
		#1;
		expect_reg(REG_START, 32'h0);
		check_word("pixel count after idle", 32'(frame_len), 32'(out_cnt));
	endtask

	initial begin : main_seq
		lfsr        = 32'hdb9c23e5;
		rstn        = 1'b0;
		hsel        = 1'b0;
		hready      = 1'b1;
		htrans      = HTRANS_IDLE;
		hwrite      = 1'b0;
		haddr       = '0;
		hwdata      = '0;
		out_cnt     = 0;
		frame_len   = 0;
		test_name   = "reset";
		// Reference starts from the register reset values
		cfg_w       = MAX_W;
		cfg_h       = MAX_H;
		cfg_conv3x3 = 1'b1;
		cfg_linear  = 1'b0;
		cfg_bshift  = '0;
		cfg_oshift  = '0;
		cfg_scale   = param_t'(1);
		cfg_bias    = '0;
		for (int k = 0; k < N_TAPS; k++)
			w_ref[k] = '0;
		repeat (3) @(posedge clk);
		#1;
		rstn = 1'b1;
		@(posedge clk);
		#1;

		reg_access_test();
		conv3x3_relu_test();
		conv1x1_linear_test();
		resize_test();
		busy_start_test();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- tb.f
+incdir+sim
rtl/cnn_pkg.sv
rtl/ahb_cfg_slave.sv
rtl/conv_frame_ctrl.sv
rtl/window_fetch.sv
rtl/conv_mac.sv
rtl/requant_act.sv
rtl/cnn_conv_top.sv
sim/tb_cnn_conv.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_cnn_conv -Mdir obj_dir -o vsim \
	&& { out=$(./obj_dir/vsim 2>&1); printf '%s\n' "$out"; printf '%s\n' "$out" | grep -q "TESTS PASSED"; } \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
